// File: common/fetch_pkg.sv
package fetch_pkg;

  //////////////////////////////
  // shared memory bus
  //////////////////////////////

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_e;

  typedef logic [3:0]  mem_tag_t;  // zero means not accepted
  typedef logic [63:0] addr_t;
  typedef logic [63:0] line_t;
  typedef logic [31:0] inst_t;

  typedef struct packed {
    bus_command_e command;
    addr_t        addr;
    line_t        data;
  } mem_req_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_packet_t;

  //////////////////////////////
  // geometry
  //////////////////////////////

  localparam int    default_cache_lines = 32;
  localparam int    default_queue_depth = 4;
  localparam int    line_offset_bits    = 3;   // 8-byte lines
  localparam int    code_addr_bits      = 16;  // 64 KB code space
  localparam addr_t reset_pc            = '0;

  // tag is what is left of the code address after offset and index
  function automatic int tag_bits(input int lines);
    return code_addr_bits - line_offset_bits - $clog2(lines);
  endfunction

endpackage

// File: icache/cache_mem.sv
`timescale 1ns/1ns

module cache_mem #(
  parameter int cache_lines = fetch_pkg::default_cache_lines
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       wr_en,
  input  logic [$clog2(cache_lines)-1:0]             wr_idx,
  input  logic [fetch_pkg::tag_bits(cache_lines)-1:0] wr_tag,
  input  fetch_pkg::line_t                           wr_data,
  input  logic [$clog2(cache_lines)-1:0]             rd_idx,
  input  logic [fetch_pkg::tag_bits(cache_lines)-1:0] rd_tag,
  output fetch_pkg::line_t                           rd_data,
  output logic                                       rd_valid
);
  import fetch_pkg::*;

  localparam int tag_w = tag_bits(cache_lines);

  line_t                  data_mem [cache_lines];
  logic [tag_w-1:0]       tag_mem  [cache_lines];
  logic [cache_lines-1:0] valid_bits;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;  // every line starts invalid
    end else if (wr_en) begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // combinational read, valid only on tag match
  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl #(
  parameter int cache_lines = fetch_pkg::default_cache_lines
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::addr_t    fetch_pc,
  output logic                hit,
  output fetch_pkg::line_t    line,
  output fetch_pkg::mem_req_t bus_req,
  input  fetch_pkg::mem_tag_t bus_response,
  input  fetch_pkg::mem_tag_t reply_tag,
  input  fetch_pkg::line_t    reply_data
);
  import fetch_pkg::*;

  localparam int idx_w = $clog2(cache_lines);
  localparam int tag_w = tag_bits(cache_lines);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } state_e;

  state_e           state, next_state;
  mem_tag_t         pend_tag;
  logic [idx_w-1:0] pc_idx, miss_idx;
  logic [tag_w-1:0] pc_tag, miss_tag;
  logic             rd_valid;
  logic             wr_en;
  logic             requesting;

  assign pc_idx = fetch_pc[line_offset_bits +: idx_w];
  assign pc_tag = fetch_pc[line_offset_bits + idx_w +: tag_w];

  cache_mem #(
    .cache_lines(cache_lines)
  ) i_cache_mem (
    .clock   (clock),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_idx  (miss_idx),
    .wr_tag  (miss_tag),
    .wr_data (reply_data),
    .rd_idx  (pc_idx),
    .rd_tag  (pc_tag),
    .rd_data (line),
    .rd_valid(rd_valid)
  );

  assign hit        = (state == st_idle) && rd_valid;  // no hits while refilling
  assign requesting = (bus_req.command == bus_load);

  //////////////////////////////
  // miss FSM
  //////////////////////////////

  always_comb begin
    next_state = state;
    bus_req    = '{command: bus_none, addr: '0, data: '0};
    wr_en      = 1'b0;
    case (state)
      st_idle: begin
        if (!rd_valid) begin  // load goes out in the miss cycle
          bus_req.command = bus_load;
          bus_req.addr    = addr_t'({pc_tag, pc_idx, {line_offset_bits{1'b0}}});
          next_state      = (bus_response != '0) ? st_wait : st_request;
        end
      end
      st_request: begin
        bus_req.command = bus_load;  // held until accepted
        bus_req.addr    = addr_t'({miss_tag, miss_idx, {line_offset_bits{1'b0}}});
        if (bus_response != '0) next_state = st_wait;
      end
      st_wait: begin
        if (reply_tag == pend_tag) begin
          wr_en      = 1'b1;
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= st_idle;
      pend_tag <= '0;
    end else begin
      state <= next_state;
      if (requesting && bus_response != '0) pend_tag <= bus_response;
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && !rd_valid) begin
      miss_idx <= pc_idx;
      miss_tag <= pc_tag;
    end
  end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     redirect_valid,
  input  fetch_pkg::addr_t         redirect_pc,
  output fetch_pkg::addr_t         fetch_pc,
  input  logic                     hit,
  input  fetch_pkg::line_t         line,
  input  logic                     push_ready,
  output logic                     push_valid,
  output fetch_pkg::fetch_packet_t push_packet
);
  import fetch_pkg::*;

  addr_t pc;
  inst_t word;

  assign fetch_pc = pc;

  // pc bit 2 picks the half of the line
  assign word = pc[2] ? line[63:32] : line[31:0];

  // a redirect in the same cycle kills the push
  assign push_valid       = hit && !redirect_valid;
  assign push_packet.pc   = pc;
  assign push_packet.inst = word;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (redirect_valid) begin
      pc <= redirect_pc;
    end else if (push_valid && push_ready) begin
      pc <= pc + 64'd4;
    end
  end

endmodule

// File: logic/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
  parameter int queue_depth = fetch_pkg::default_queue_depth
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     push_valid,
  input  fetch_pkg::fetch_packet_t push_packet,
  output logic                     push_ready,
  output logic                     out_valid,
  input  logic                     out_ready,
  output fetch_pkg::fetch_packet_t out_packet
);
  import fetch_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  fetch_packet_t    entries [queue_depth];
  logic [ptr_w-1:0] head, tail;
  logic [cnt_w-1:0] count;
  logic             do_push, do_pop;

  assign out_valid  = (count != '0);
  assign out_packet = entries[head];
  assign push_ready = (count != cnt_w'(queue_depth)) || out_ready;  // pop frees a slot

  assign do_push = push_valid && push_ready && !flush;
  assign do_pop  = out_valid && out_ready && !flush;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) tail <= (tail == ptr_w'(queue_depth - 1)) ? '0 : tail + 1'b1;
      if (do_pop)  head <= (head == ptr_w'(queue_depth - 1)) ? '0 : head + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) entries[tail] <= push_packet;
  end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t icache_req,
  output fetch_pkg::mem_tag_t icache_response,
  output fetch_pkg::mem_tag_t icache_reply_tag,
  input  fetch_pkg::mem_req_t dmem_req,
  output fetch_pkg::mem_tag_t dmem_response,
  output fetch_pkg::mem_tag_t dmem_reply_tag,
  output fetch_pkg::mem_req_t bus_req,
  input  fetch_pkg::mem_tag_t mem2proc_response,
  input  fetch_pkg::mem_tag_t mem2proc_tag
);
  import fetch_pkg::*;

  localparam int num_tags = 2 ** $bits(mem_tag_t);

  logic                dmem_wins;
  logic [num_tags-1:0] tag_is_dmem;  // owner table, one bit per tag

  assign dmem_wins = (dmem_req.command != bus_none);
  assign bus_req   = dmem_wins ? dmem_req : icache_req;

  assign dmem_response   = dmem_wins ? mem2proc_response : '0;
  assign icache_response = dmem_wins ? '0 : mem2proc_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_is_dmem <= '0;
    end else if (mem2proc_response != '0) begin
      tag_is_dmem[mem2proc_response] <= dmem_wins;
    end
  end

  // reply goes to exactly one owner
  assign dmem_reply_tag   = tag_is_dmem[mem2proc_tag] ? mem2proc_tag : '0;
  assign icache_reply_tag = tag_is_dmem[mem2proc_tag] ? '0 : mem2proc_tag;

endmodule

// File: logic/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend #(
  parameter int cache_lines = fetch_pkg::default_cache_lines,
  parameter int queue_depth = fetch_pkg::default_queue_depth
) (
  input  logic                     clock,
  input  logic                     reset,
  output fetch_pkg::mem_req_t      proc2mem_req,
  input  fetch_pkg::mem_tag_t      mem2proc_response,
  input  fetch_pkg::mem_tag_t      mem2proc_tag,
  input  fetch_pkg::line_t         mem2proc_data,
  input  fetch_pkg::mem_req_t      dmem_req,
  output fetch_pkg::mem_tag_t      dmem_response,
  output fetch_pkg::mem_tag_t      dmem_reply_tag,
  input  logic                     redirect_valid,
  input  fetch_pkg::addr_t         redirect_pc,
  output logic                     out_valid,
  input  logic                     out_ready,
  output fetch_pkg::fetch_packet_t out_packet
);
  import fetch_pkg::*;

  addr_t         fetch_pc;
  logic          hit;
  line_t         line;
  mem_req_t      icache_req;
  mem_tag_t      icache_response;
  mem_tag_t      icache_reply_tag;
  logic          push_valid;
  logic          push_ready;
  fetch_packet_t push_packet;

  //////////////////////////////
  // fetch path
  //////////////////////////////

  icache_ctrl #(
    .cache_lines(cache_lines)
  ) i_icache_ctrl (
    .clock       (clock),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .hit         (hit),
    .line        (line),
    .bus_req     (icache_req),
    .bus_response(icache_response),
    .reply_tag   (icache_reply_tag),
    .reply_data  (mem2proc_data)
  );

  fetch_stage i_fetch_stage (
    .clock         (clock),
    .reset         (reset),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .fetch_pc      (fetch_pc),
    .hit           (hit),
    .line          (line),
    .push_ready    (push_ready),
    .push_valid    (push_valid),
    .push_packet   (push_packet)
  );

  fetch_queue #(
    .queue_depth(queue_depth)
  ) i_fetch_queue (
    .clock      (clock),
    .reset      (reset),
    .flush      (redirect_valid),  // taken branch drops queued packets
    .push_valid (push_valid),
    .push_packet(push_packet),
    .push_ready (push_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_packet (out_packet)
  );

  //////////////////////////////
  // shared bus
  //////////////////////////////

  mem_arbiter i_mem_arbiter (
    .clock            (clock),
    .reset            (reset),
    .icache_req       (icache_req),
    .icache_response  (icache_response),
    .icache_reply_tag (icache_reply_tag),
    .dmem_req         (dmem_req),
    .dmem_response    (dmem_response),
    .dmem_reply_tag   (dmem_reply_tag),
    .bus_req          (proc2mem_req),
    .mem2proc_response(mem2proc_response),
    .mem2proc_tag     (mem2proc_tag)
  );

endmodule

// File: dv/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
  parameter int reply_latency = 6
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t proc2mem_req,
  output fetch_pkg::mem_tag_t mem2proc_response,
  output fetch_pkg::mem_tag_t mem2proc_tag,
  output fetch_pkg::line_t    mem2proc_data
);
  import fetch_pkg::*;

  line_t       mem [8192];  // 64 KB of 8-byte lines
  logic        busy;
  mem_tag_t    next_tag;
  mem_tag_t    pend_tag;
  logic [12:0] pend_line;
  int unsigned wait_cycles;

  // one transaction at a time
  assign mem2proc_response = (!busy && proc2mem_req.command != bus_none) ? next_tag : '0;
  assign mem2proc_tag      = (busy && wait_cycles == 0) ? pend_tag : '0;
  assign mem2proc_data     = mem[pend_line];

  always @(posedge clock) begin
    if (reset) begin
      busy        <= 1'b0;
      next_tag    <= 4'd1;
      pend_tag    <= '0;
      pend_line   <= '0;
      wait_cycles <= 0;
    end else if (mem2proc_response != '0) begin
      busy        <= 1'b1;
      pend_tag    <= next_tag;
      pend_line   <= proc2mem_req.addr[15:3];
      wait_cycles <= reply_latency - 1;
      next_tag    <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // tags 1 to 15
    end else if (busy) begin
      if (wait_cycles == 0) busy <= 1'b0;
      else wait_cycles <= wait_cycles - 1;
    end
  end

  always @(posedge clock) begin
    if (!reset && mem2proc_response != '0 && proc2mem_req.command == bus_store) begin
      mem[proc2mem_req.addr[15:3]] <= proc2mem_req.data;
    end
  end

endmodule

// File: dv/fetch_frontend_tb.sv
`timescale 1ns/1ns

module fetch_frontend_tb;
  import fetch_pkg::*;

  localparam int max_events    = 16;
  localparam int run_timeout   = 3000;
  localparam int reply_timeout = 60;

  logic          clock;
  logic          reset;
  mem_req_t      proc2mem_req;
  mem_req_t      dmem_req;
  mem_tag_t      mem2proc_response;
  mem_tag_t      mem2proc_tag;
  mem_tag_t      dmem_response;
  mem_tag_t      dmem_reply_tag;
  line_t         mem2proc_data;
  logic          redirect_valid;
  addr_t         redirect_pc;
  logic          out_valid;
  logic          out_ready;
  fetch_packet_t out_packet;

  inst_t image [16384];      // expected memory image, one word per entry
  logic  line_loaded [8192];
  int    red_count [max_events];
  addr_t red_pc [max_events];
  int    data_cycle [max_events];
  addr_t data_addr [max_events];
  int    stall_lo [max_events];
  int    stall_hi [max_events];
  int    num_red, num_data, num_stall, expected_total;

  int            cycle, delivered, red_idx, data_idx, accept_wait, reply_wait;
  logic          data_active, tag_waiting, was_stalled;
  mem_tag_t      data_tag;
  addr_t         data_line_addr, expect_pc;
  fetch_packet_t held;

  fetch_frontend i_fetch_frontend (
    .clock(clock), .reset(reset),
    .proc2mem_req(proc2mem_req), .mem2proc_response(mem2proc_response),
    .mem2proc_tag(mem2proc_tag), .mem2proc_data(mem2proc_data),
    .dmem_req(dmem_req), .dmem_response(dmem_response), .dmem_reply_tag(dmem_reply_tag),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .out_valid(out_valid), .out_ready(out_ready), .out_packet(out_packet)
  );

  mem_model i_mem_model (
    .clock(clock), .reset(reset), .proc2mem_req(proc2mem_req),
    .mem2proc_response(mem2proc_response), .mem2proc_tag(mem2proc_tag),
    .mem2proc_data(mem2proc_data)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    stop_on_error();
  endtask

  task automatic check_value(input string name, input logic [95:0] expected,
                             input logic [95:0] actual);
    if (expected !== actual) begin
      $display("mismatch: %s expected %h actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  function automatic logic in_stall_window(input int c);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < num_stall; i++) begin
      if (c >= stall_lo[i] && c <= stall_hi[i]) hit = 1'b1;
    end
    return hit;
  endfunction

  //////////////////////////////
  // stimulus file
  //////////////////////////////

  task automatic load_stimulus();
    int          fd;
    int          fields;
    string       text;
    byte         kind;
    logic [63:0] a, b;
    for (int i = 0; i < 16384; i++) image[i] = {8'h13, 24'(i * 4)};  // byte address pattern
    fd = $fopen("dv/fetch_stimulus.txt", "r");
    if (fd == 0) fail_run("could not open dv/fetch_stimulus.txt");
    while ($fgets(text, fd) != 0) begin
      if (text.len() < 2 || text[0] == "#") continue;
      fields = $sscanf(text, "%c %h %h", kind, a, b);
      if (fields < 3) fail_run({"badly formed stimulus line: ", text});
      case (kind)
        "m": image[a[15:2]] = b[31:0];
        "r": begin
          red_count[num_red] = int'(a);
          red_pc[num_red]    = b;
          num_red++;
        end
        "d": begin
          data_cycle[num_data] = int'(a);
          data_addr[num_data]  = b;
          num_data++;
        end
        "s": begin
          stall_lo[num_stall] = int'(a);
          stall_hi[num_stall] = int'(b);
          num_stall++;
        end
        "n": expected_total = int'(a);
        default: fail_run({"unknown stimulus line: ", text});
      endcase
    end
    $fclose(fd);
    for (int l = 0; l < 8192; l++) begin
      i_mem_model.mem[l] = {image[2 * l + 1], image[2 * l]};
      line_loaded[l]     = 1'b0;
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h3ff));
    reset            = 1'b1;
    dmem_req.command = bus_none;
    dmem_req.addr    = '0;
    dmem_req.data    = '0;
    redirect_valid   = 1'b0;
    redirect_pc      = '0;
    out_ready        = 1'b0;
    num_red          = 0;
    num_data         = 0;
    num_stall        = 0;
    expected_total   = 0;
    cycle            = 0;
    delivered        = 0;
    red_idx          = 0;
    data_idx         = 0;
    data_active      = 1'b0;
    tag_waiting      = 1'b0;
    was_stalled      = 1'b0;
    expect_pc        = reset_pc;
    load_stimulus();
    repeat (10) @(posedge clock);
    #2 reset = 1'b0;

    while (delivered < expected_total || data_active || tag_waiting || data_idx < num_data) begin
      @(posedge clock);
      if (cycle > run_timeout) begin
        fail_run($sformatf("timeout: %0d of %0d instructions delivered", delivered,
                           expected_total));
      end
      if (was_stalled) check_value("stalled packet holds", held, out_packet);
      was_stalled = out_valid && !out_ready && !redirect_valid;
      held        = out_packet;
      if (out_valid && out_ready) begin
        check_value("fetch pc", expect_pc, out_packet.pc);
        check_value("fetch inst", image[expect_pc[15:2]], out_packet.inst);
        expect_pc += 4;
        delivered++;
      end
      if (dmem_req.command != bus_none) begin
        check_value("data priority", dmem_req.command, proc2mem_req.command);
        check_value("data priority addr", dmem_req.addr, proc2mem_req.addr);
      end else if (proc2mem_req.command == bus_load && mem2proc_response != '0) begin
        if (line_loaded[proc2mem_req.addr[15:3]]) begin
          fail_run($sformatf("cached line %h was fetched from memory again",
                             proc2mem_req.addr));
        end
        line_loaded[proc2mem_req.addr[15:3]] = 1'b1;
      end
      if (data_active) begin
        accept_wait++;
        if (accept_wait > reply_timeout) fail_run("data request was never accepted");
        if (dmem_response != '0) begin
          data_tag    = dmem_response;
          data_active = 1'b0;
          tag_waiting = 1'b1;
          reply_wait  = 0;
        end
      end
      if (dmem_reply_tag != '0) begin
        if (!tag_waiting) fail_run("data reply tag seen with no data request outstanding");
        check_value("data reply tag", data_tag, dmem_reply_tag);
        check_value("data reply line",
                    {image[data_line_addr[15:2] + 1], image[data_line_addr[15:2]]},
                    mem2proc_data);
        tag_waiting = 1'b0;
      end else if (tag_waiting) begin
        reply_wait++;
        if (reply_wait > reply_timeout) fail_run("data reply tag never came back");
      end

      #2;  // drive after the edge
      cycle++;
      redirect_valid = 1'b0;
      if (red_idx < num_red && delivered == red_count[red_idx]) begin
        redirect_valid = 1'b1;
        redirect_pc    = red_pc[red_idx];
        expect_pc      = red_pc[red_idx];  // old path must not show up
        out_ready      = 1'b0;
        red_idx++;
      end else begin
        out_ready = (delivered < expected_total) && !in_stall_window(cycle) &&
                    (($urandom % 4) != 0);
      end
      if (!data_active) dmem_req.command = bus_none;
      if (!data_active && !tag_waiting && data_idx < num_data &&
          cycle >= data_cycle[data_idx]) begin
        dmem_req.command = bus_load;
        dmem_req.addr    = data_addr[data_idx];
        data_line_addr   = {data_addr[data_idx][63:3], 3'b000};
        data_active      = 1'b1;
        accept_wait      = 0;
        data_idx++;
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: dv/fetch_stimulus.txt
# columns in hex: kind a b
# m byte_addr word | r after_count target_pc | d cycle data_addr | s first_cycle last_cycle | n total 0
m 0 00000013
m 4 00100093
m 8 00200113
m c 00308193
m 10 00410213
m 14 00518293
m 18 fe000ee3
m 1c 00620313
m 80 00730393
m 84 00838413
m 8000 cafe0001
m 8004 cafe0002
m 8010 beef0010
m 8014 beef0014
m 8100 d00d0100
m 8104 d00d0104
r 8 10
r 14 80
d 2 8000
d 1e 8010
d 46 8100
s 28 37
s 5a 64
n 20 0

// File: vlog.f
common/fetch_pkg.sv
icache/cache_mem.sv
icache/icache_ctrl.sv
logic/fetch_stage.sv
logic/fetch_queue.sv
logic/mem_arbiter.sv
logic/fetch_frontend.sv
dv/mem_model.sv
dv/fetch_frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINT      ?= --lint-only --timing
TOP       ?= fetch_frontend_tb
RTL_TOP   ?= fetch_frontend
FILELIST  ?= vlog.f
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
